/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_zx_io
RTL_TOP    ?= zx_io_top
FILELIST   ?= filelist.f
BUILD      ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) hdl/zx_params.svh
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* filelist.f */
+incdir+hdl
hdl/zx_pkg.sv
hdl/cpu_bus_sync.sv
hdl/zx_ports.sv
hdl/mem_pager.sv
hdl/zx_io_top.sv
sim/tb_zx_io.sv

/* hdl/cpu_bus_sync.sv */
`timescale 1ns/1ns

module cpu_bus_sync (
    input  logic           rst_n,
    input  logic           clk28,

    input  zx_pkg::addr_t  a,
    input  zx_pkg::byte_t  d_in,
    input  logic           mreq_n,
    input  logic           iorq_n,
    input  logic           rd_n,
    input  logic           wr_n,
    input  logic           m1_n,

    output zx_pkg::addr_t  bus_a,
    output zx_pkg::byte_t  bus_d,
    output logic           ioreq,
    output logic           rd,
    output logic           wr,
    output logic           m1,
    output logic           mreq_rise
);
    import zx_pkg::*;

    // strobe order: m1, wr, rd, iorq, mreq.
    logic [4:0] strobe_s1;
    logic [4:0] strobe_s2;
    logic       mreq_q;

    addr_t a_s1;
    addr_t a_s2;
    byte_t d_s1;
    byte_t d_s2;

    // ~~~~ strobes ~~~~~~~~~~~~~
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            strobe_s1 <= '0;
            strobe_s2 <= '0;
            mreq_q    <= 1'b0;
        end else begin
            strobe_s1 <= ~{m1_n, wr_n, rd_n, iorq_n, mreq_n}; // now active high.
            strobe_s2 <= strobe_s1;
            mreq_q    <= strobe_s2[0];
        end
    end

    // ~~~~ address and data ~~~~
    // two stages, in step with the strobes.
    always_ff @(posedge clk28) begin
        a_s1 <= a;
        a_s2 <= a_s1;
        d_s1 <= d_in;
        d_s2 <= d_s1;
    end

    assign bus_a = a_s2;
    assign bus_d = d_s2;

    assign m1    = strobe_s2[4];
    assign wr    = strobe_s2[3];
    assign rd    = strobe_s2[2];
    assign ioreq = strobe_s2[1];

    assign mreq_rise = strobe_s2[0] & ~mreq_q; // first cycle of mreq.

    // the cpu never reads and writes in the same cycle.
    a_rd_wr_excl: assert property (@(posedge clk28) disable iff (!rst_n)
        !(rd && wr));

endmodule

/* hdl/mem_pager.sv */
`timescale 1ns/1ns
`include "zx_params.svh"

module mem_pager (
    input  logic               rst_n,
    input  logic               clk28,
    input  zx_pkg::addr_t      bus_a,
    input  zx_pkg::machine_t   machine,
    input  logic               rom_page128,
    input  zx_pkg::bank_t      ram_page128,
    input  zx_pkg::bank_t      ram_pageext,
    input  logic [2:0]         port_1ffd,
    input  logic [4:0]         port_dffd,

    output zx_pkg::phys_page_t phys_page,
    output logic [1:0]         rom_sel,
    output logic               rom_active
);
    import zx_pkg::*;

    logic       special;
    logic       ext_en;
    logic [1:0] cpu_bank;
    bank_t      special_page;
    phys_page_t page_next;
    logic       rom_next;

    assign cpu_bank = bus_a[15:14];
    assign special  = machine == MACHINE_S3 && port_1ffd[0]; // +3 all-ram.
    // dffd only loads outside the pentagon under magic.
    assign ext_en   = machine == MACHINE_PENT || port_dffd != '0;

    // +3 all-ram configs: 0123, 4567, 4563, 4763.
    always_comb begin
        case (port_1ffd[2:1])
            2'd0:    special_page = {1'b0, cpu_bank};
            2'd1:    special_page = {1'b1, cpu_bank};
            2'd2:    special_page = (cpu_bank == 2'd3) ? 3'd3 : {1'b1, cpu_bank};
            default: special_page = (cpu_bank == 2'd3) ? 3'd3 :
                                    (cpu_bank == 2'd1) ? 3'd7 : {1'b1, cpu_bank};
        endcase
    end

    always_comb begin
        rom_next  = 1'b0;
        page_next = '0;
        if (special) begin
            page_next = {3'b000, special_page};
        end else begin
            case (cpu_bank)
                2'd0: rom_next  = 1'b1;
                2'd1: page_next = {3'b000, `BANK_AT_4000};
                2'd2: page_next = {3'b000, `BANK_AT_8000};
                default: begin
                    if (machine == MACHINE_S48)
                        page_next = '0;
                    else if (ext_en)
                        page_next = {ram_pageext, ram_page128};
                    else
                        page_next = {3'b000, ram_page128};
                end
            endcase
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            phys_page  <= '0;
            rom_sel    <= '0;
            rom_active <= 1'b0;
        end else begin
            phys_page  <= page_next;
            rom_sel    <= {machine == MACHINE_S3 && port_1ffd[2], rom_page128};
            rom_active <= rom_next;
        end
    end

    a_special_no_rom: assert property (@(posedge clk28) disable iff (!rst_n)
        special |=> !rom_active);

endmodule

/* hdl/zx_io_top.sv */
`timescale 1ns/1ns

module zx_io_top (
    input  logic               rst_n,
    input  logic               clk28,

    input  zx_pkg::addr_t      a,
    input  zx_pkg::byte_t      d_in,
    input  logic               mreq_n,
    input  logic               iorq_n,
    input  logic               rd_n,
    input  logic               wr_n,
    input  logic               m1_n,

    input  zx_pkg::machine_t   machine,
    input  logic               en_kempston,
    input  logic               en_sinclair,
    input  logic               magic_map,
    input  logic               basic48_paged,
    input  logic               port_ff_active,

    input  zx_pkg::byte_t      port_ff_data,
    input  zx_pkg::kbd_t       kd,
    input  zx_pkg::byte_t      kempston_data,
    input  logic               tape_in,

    output zx_pkg::byte_t      d_out,
    output logic               d_out_active,
    output logic               tape_out,
    output logic               beeper,
    output zx_pkg::border_t    border,
    output logic               plus3_drd,
    output logic               plus3_dwr,
    output logic               plus3_mtr,
    output logic               video_page,

    output zx_pkg::phys_page_t phys_page,
    output logic [1:0]         rom_sel,
    output logic               rom_active
);
    import zx_pkg::*;

    addr_t      bus_a;
    byte_t      bus_d;
    logic       ioreq;
    logic       rd;
    logic       wr;
    logic       m1;
    logic       mreq_rise;

    logic       rom_page128;
    bank_t      ram_page128;
    bank_t      ram_pageext;
    logic [2:0] port_1ffd;
    logic [4:0] port_dffd;

    cpu_bus_sync u_sync (
        .rst_n, .clk28,
        .a, .d_in, .mreq_n, .iorq_n, .rd_n, .wr_n, .m1_n,
        .bus_a, .bus_d, .ioreq, .rd, .wr, .m1, .mreq_rise
    );

    zx_ports u_ports (
        .rst_n, .clk28, .en_kempston, .en_sinclair,
        .bus_a, .bus_d, .ioreq, .rd, .wr, .m1, .mreq_rise,
        .d_out, .d_out_active,
        .machine, .basic48_paged, .port_ff_active, .port_ff_data,
        .kd, .kempston_data, .magic_map, .tape_in,
        .tape_out, .beeper, .border, .video_page,
        .rom_page128, .ram_page128, .ram_pageext, .port_1ffd, .port_dffd,
        .plus3_drd, .plus3_dwr, .plus3_mtr
    );

    mem_pager u_pager (
        .rst_n, .clk28, .bus_a, .machine,
        .rom_page128, .ram_page128, .ram_pageext, .port_1ffd, .port_dffd,
        .phys_page, .rom_sel, .rom_active
    );

endmodule

/* hdl/zx_params.svh */
`ifndef ZX_PARAMS_SVH
`define ZX_PARAMS_SVH

// ~~~~ port addresses ~~~~~~
// pentagon extended paging, fully decoded.
`define PORT_DFFD_ADDR   16'hDFFD

// kempston matches on the low six address bits.
`define PORT_KEMPSTON_LO 6'h1F

// ~~~~ tr-dos ~~~~~~~~~~~~~~
// m1 fetch from this page enters the dos rom.
`define TRDOS_ENTRY_HI   8'h3D

// ~~~~ memory map ~~~~~~~~~~
// fixed pages behind #4000 and #8000.
`define BANK_AT_4000     3'd5
`define BANK_AT_8000     3'd2

// ~~~~ reset values ~~~~~~~~
// no key pressed.
`define KD_IDLE          5'b11111

`endif

/* hdl/zx_pkg.sv */
package zx_pkg;

    // ~~~~ machine ~~~~~~~~~~~~~
    // machine type picks port decoding and paging rules.
    typedef enum logic [1:0] {
        MACHINE_S48  = 2'd0, // 48k, no paging.
        MACHINE_S128 = 2'd1, // 128k with port #7ffd.
        MACHINE_S3   = 2'd2, // +3 with #1ffd and fdc ports.
        MACHINE_PENT = 2'd3  // pentagon, #dffd extension.
    } machine_t;

    // ~~~~ bus ~~~~~~~~~~~~~~~~~
    typedef logic [7:0]  byte_t;  // z80 data bus.
    typedef logic [15:0] addr_t;  // z80 address bus.

    // ~~~~ memory ~~~~~~~~~~~~~~
    // page within one 128k group.
    typedef logic [2:0] bank_t;

    // physical 16k page.
    // bits 5..3 come from the extended port.
    typedef logic [5:0] phys_page_t;

    // ~~~~ keyboard / video ~~~~
    // one half-row of keys, low when pressed.
    typedef logic [4:0] kbd_t;

    typedef logic [2:0] border_t; // grb colour.

endpackage

/* hdl/zx_ports.sv */
`timescale 1ns/1ns
`include "zx_params.svh"

module zx_ports (
    input  logic              rst_n,
    input  logic              clk28,
    input  logic              en_kempston,
    input  logic              en_sinclair,

    input  zx_pkg::addr_t     bus_a,
    input  zx_pkg::byte_t     bus_d,
    input  logic              ioreq,
    input  logic              rd,
    input  logic              wr,
    input  logic              m1,
    input  logic              mreq_rise,

    output zx_pkg::byte_t     d_out,
    output logic              d_out_active,

    input  zx_pkg::machine_t  machine,
    input  logic              basic48_paged,
    input  logic              port_ff_active,
    input  zx_pkg::byte_t     port_ff_data,
    input  zx_pkg::kbd_t      kd,
    input  zx_pkg::byte_t     kempston_data,
    input  logic              magic_map,
    input  logic              tape_in,

    output logic              tape_out,
    output logic              beeper,
    output zx_pkg::border_t   border,
    output logic              video_page,
    output logic              rom_page128,
    output zx_pkg::bank_t     ram_page128,
    output zx_pkg::bank_t     ram_pageext,
    output logic [2:0]        port_1ffd,
    output logic [4:0]        port_dffd,

    output logic              plus3_drd,
    output logic              plus3_dwr,
    output logic              plus3_mtr
);
    import zx_pkg::*;

    logic  trdos;
    logic  port_ff_rd;
    logic  port_fe_rd;
    logic  kempston_rd;
    logic  lock_7ffd;
    kbd_t  kd0;
    kbd_t  sinclair_lo;
    kbd_t  sinclair_hi;
    byte_t port_fe_data;

    logic  port_fe_cs;
    logic  port_7ffd_cs;
    logic  port_dffd_cs;
    logic  port_1ffd_cs;
    logic  port_fdc_cs;

    // ~~~~ port #ff ~~~~~~~~~~~~
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            trdos <= 1'b0;
        end else if (mreq_rise && m1) begin
            if (bus_a[15:8] == `TRDOS_ENTRY_HI && basic48_paged)
                trdos <= 1'b1;
            else if (bus_a[15] || bus_a[14]) // left the rom area.
                trdos <= 1'b0;
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            port_ff_rd <= 1'b0;
        else
            port_ff_rd <= ioreq && rd && bus_a[7:0] == 8'hFF && port_ff_active &&
                          !trdos && !magic_map && machine != MACHINE_S3;
    end

    // ~~~~ port #fe ~~~~~~~~~~~~
    assign port_fe_cs   = ioreq && !bus_a[0];
    assign port_fe_data = {1'b1, tape_in, 1'b1, kd0};

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            port_fe_rd <= 1'b0;
        end else begin
            port_fe_rd <= port_fe_cs && rd;
        end
    end

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            beeper   <= 1'b0;
            tape_out <= 1'b0;
            border   <= '0;
        end else if (port_fe_cs && wr) begin
            beeper   <= bus_d[4];
            tape_out <= bus_d[3];
            border   <= bus_d[2:0];
        end
    end

    // sinclair stick on the 6-0 row.
    assign sinclair_lo = bus_a[12] ? `KD_IDLE :
        ~{kempston_data[1], kempston_data[0], kempston_data[2],
          kempston_data[3], kempston_data[4]};
    // extra buttons on the b-space row.
    assign sinclair_hi = bus_a[15] ? `KD_IDLE :
        ~{1'b0, kempston_data[6], kempston_data[5], 2'b00};

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            kd0 <= `KD_IDLE;
        else if (en_sinclair)
            kd0 <= kd & sinclair_lo & sinclair_hi;
        else
            kd0 <= kd;
    end

    // ~~~~ port #7ffd ~~~~~~~~~~
    // a14 is ignored on plain 128k decoding.
    assign port_7ffd_cs = ioreq && !bus_a[1] && !bus_a[15] &&
                          (bus_a[14] || (!magic_map && machine != MACHINE_S3)) &&
                          (machine != MACHINE_S48 || magic_map) &&
                          (!lock_7ffd || port_dffd[4]);

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            ram_page128 <= '0;
            video_page  <= 1'b0;
            rom_page128 <= 1'b0;
            lock_7ffd   <= 1'b0;
        end else if (port_7ffd_cs && wr) begin
            ram_page128 <= bus_d[2:0];
            video_page  <= bus_d[3];
            rom_page128 <= bus_d[4];
            lock_7ffd   <= bus_d[5];
        end
    end

    // ~~~~ port #dffd ~~~~~~~~~~
    assign port_dffd_cs = ioreq && bus_a == `PORT_DFFD_ADDR &&
                          (machine == MACHINE_PENT || magic_map);

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            ram_pageext <= '0;
            port_dffd   <= '0;
        end else if (port_dffd_cs && wr) begin
            ram_pageext <= bus_d[2:0];
            port_dffd   <= bus_d[4:0]; // bit 4 lifts the 7ffd lock.
        end
    end

    // ~~~~ port #1ffd ~~~~~~~~~~
    assign port_1ffd_cs = ioreq && bus_a[15:12] == 4'b0001 && !bus_a[1] &&
                          (machine == MACHINE_S3 || magic_map);

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            port_1ffd <= '0;
            plus3_mtr <= 1'b1;
        end else if (port_1ffd_cs && wr) begin
            port_1ffd <= bus_d[2:0];
            plus3_mtr <= ~bus_d[3]; // motor on when low.
        end
    end

    // ~~~~ fdc #2ffd/#3ffd ~~~~~
    assign port_fdc_cs = ioreq && bus_a[15:13] == 3'b001 && !bus_a[1] &&
                         machine == MACHINE_S3;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            plus3_drd <= 1'b1;
            plus3_dwr <= 1'b1;
        end else begin
            plus3_drd <= ~(port_fdc_cs && rd);
            plus3_dwr <= ~(port_fdc_cs && wr);
        end
    end

    // ~~~~ kempston ~~~~~~~~~~~~
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n)
            kempston_rd <= 1'b0;
        else
            kempston_rd <= en_kempston && ioreq && rd &&
                           bus_a[5:0] == `PORT_KEMPSTON_LO;
    end

    // ~~~~ read mux ~~~~~~~~~~~~
    assign d_out_active = kempston_rd | port_fe_rd | port_ff_rd;

    always_comb begin
        if (kempston_rd)
            d_out = kempston_data;
        else if (port_fe_rd)
            d_out = port_fe_data;
        else
            d_out = port_ff_data; // floating bus.
    end

    // the three read decoders never overlap.
    a_rd_sel_onehot: assert property (@(posedge clk28) disable iff (!rst_n)
        $onehot0({kempston_rd, port_fe_rd, port_ff_rd}));

endmodule

/* sim/tb_zx_io.sv */
`timescale 1ns/1ns
`include "zx_params.svh"

module tb_zx_io;
    import zx_pkg::*;

    localparam int N_TESTS  = 6;
    localparam int N_CYCLES = 60;
    localparam int LIMIT    = N_TESTS * N_CYCLES * 10 + 600; // 10 clocks per bus cycle.

    logic rst_n;
    logic clk28;
    addr_t a;
    byte_t d_in;
    logic mreq_n, iorq_n, rd_n, wr_n, m1_n;
    machine_t machine;
    logic en_kempston, en_sinclair, magic_map, basic48_paged, port_ff_active;
    byte_t port_ff_data;
    kbd_t kd;
    byte_t kempston_data;
    logic tape_in;

    byte_t d_out;
    logic d_out_active, tape_out, beeper, plus3_drd, plus3_dwr, plus3_mtr, video_page;
    border_t border;
    phys_page_t phys_page;
    logic [1:0] rom_sel;
    logic rom_active;

    // reference model state.
    border_t m_border;
    logic m_beeper, m_tape, m_video, m_rom128, m_lock, m_mtr, m_trdos;
    bank_t m_page128;
    bank_t m_ext;
    logic [4:0] m_dffd;
    logic [2:0] m_1ffd;

    int errors;
    int checks;
    int cycles;
    string test_name;

    zx_io_top dut (.*);

    initial begin
        clk28 = 1'b0;
        forever #50 clk28 = ~clk28;
    end

    always @(posedge clk28) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ~~~~ compare tasks ~~~~~~~~
    task automatic check_byte(input string what, input byte_t exp, input byte_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_page(input string what, input phys_page_t exp, input phys_page_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_border(input string what, input border_t exp, input border_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_sel(input string what, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // ~~~~ stimulus ~~~~~~~~~~~~~
    function automatic addr_t pick_addr();
        addr_t r;
        r = addr_t'($urandom);
        if ($urandom % 2 == 0)
            return r;
        case ($urandom % 8)
            0: return {r[15:8], 8'hFE};
            1: return 16'h7FFD;
            2: return `PORT_DFFD_ADDR;
            3: return 16'h1FFD;
            4: return 16'h2FFD;
            5: return 16'h3FFD;
            6: return {r[15:8], 8'h1F};
            default: return {r[15:8], 8'hFF};
        endcase
    endfunction

    // memory map as seen by the cpu.
    task automatic expected_page(input addr_t addr, output phys_page_t pg, output logic rom);
        logic [1:0] bank;
        bank = addr[15:14];
        pg = '0;
        rom = 1'b0;
        if (machine == MACHINE_S3 && m_1ffd[0]) begin
            case (m_1ffd[2:1])
                2'd0: pg = {4'd0, bank};        // 0 1 2 3.
                2'd1: pg = {4'd1, bank};        // 4 5 6 7.
                2'd2: pg = (bank == 2'd3) ? 6'd3 : {4'd1, bank};
                default: pg = (bank == 2'd3) ? 6'd3 : (bank == 2'd1) ? 6'd7 : {4'd1, bank};
            endcase
        end else if (bank == 2'd0) begin
            rom = 1'b1;
        end else if (bank == 2'd1) begin
            pg = 6'd5;
        end else if (bank == 2'd2) begin
            pg = 6'd2;
        end else if (machine != MACHINE_S48) begin
            pg = {m_ext, m_page128}; // ext stays zero unless dffd was written.
        end
    endtask

    task automatic bus_cycle(input logic is_io, input logic is_wr, input logic is_m1,
                             input addr_t addr, input byte_t data);
        kbd_t keys;
        kbd_t kd_v;
        byte_t joy;
        byte_t ffd;
        logic tin;
        logic kemp, fe, ff, fdc;
        byte_t exp_d;
        phys_page_t pg;
        logic rom;
        kd_v = kbd_t'($urandom);
        joy = byte_t'($urandom);
        ffd = byte_t'($urandom);
        tin = 1'($urandom);
        keys = kd_v;
        if (en_sinclair && !addr[12])
            keys = keys & ~{joy[1], joy[0], joy[2], joy[3], joy[4]};
        if (en_sinclair && !addr[15])
            keys = keys & {1'b1, ~joy[6], ~joy[5], 2'b11};
        kemp = is_io && !is_wr && en_kempston && addr[5:0] == `PORT_KEMPSTON_LO;
        fe = is_io && !is_wr && !addr[0];
        ff = is_io && !is_wr && addr[7:0] == 8'hFF && port_ff_active && !m_trdos &&
             !magic_map && machine != MACHINE_S3;
        exp_d = kemp ? joy : fe ? {1'b1, tin, 1'b1, keys} : ffd;
        fdc = is_io && machine == MACHINE_S3 && addr[15:13] == 3'b001 && !addr[1];
        if (is_io && is_wr) begin
            if (!addr[0]) begin
                m_border = data[2:0];
                m_tape = data[3];
                m_beeper = data[4];
            end
            // 7ffd needs a15 low; a14 only matters on the +3 and under magic.
            if (!addr[1] && !addr[15] && (machine != MACHINE_S48 || magic_map) &&
                (addr[14] || !(magic_map || machine == MACHINE_S3)) &&
                (!m_lock || m_dffd[4])) begin
                {m_lock, m_rom128, m_video, m_page128} = data[5:0];
            end
            if (addr == `PORT_DFFD_ADDR && (machine == MACHINE_PENT || magic_map)) begin
                m_dffd = data[4:0];
                m_ext = data[2:0];
            end
            if (addr[15:12] == 4'h1 && !addr[1] && (machine == MACHINE_S3 || magic_map)) begin
                m_1ffd = data[2:0];
                m_mtr = !data[3];
            end
        end
        expected_page(addr, pg, rom);

        @(posedge clk28);
        a <= addr;
        d_in <= data;
        kd <= kd_v;
        kempston_data <= joy;
        port_ff_data <= ffd;
        tape_in <= tin;
        iorq_n <= !is_io;
        mreq_n <= is_io;
        rd_n <= is_wr;
        wr_n <= !is_wr;
        m1_n <= !is_m1;
        repeat (4) @(posedge clk28);
        @(negedge clk28);
        check_bit("d_out_active", kemp | fe | ff, d_out_active);
        if (kemp | fe | ff)
            check_byte("d_out", exp_d, d_out);
        check_border("border", m_border, border);
        check_bit("beeper", m_beeper, beeper);
        check_bit("tape_out", m_tape, tape_out);
        check_bit("video_page", m_video, video_page);
        check_bit("plus3_mtr", m_mtr, plus3_mtr);
        check_bit("plus3_drd", !(fdc && !is_wr), plus3_drd);
        check_bit("plus3_dwr", !(fdc && is_wr), plus3_dwr);
        check_page("phys_page", pg, phys_page);
        check_bit("rom_active", rom, rom_active);
        check_sel("rom_sel", {machine == MACHINE_S3 && m_1ffd[2], m_rom128}, rom_sel);
        @(posedge clk28);
        @(posedge clk28);
        iorq_n <= 1'b1;
        mreq_n <= 1'b1;
        rd_n <= 1'b1;
        wr_n <= 1'b1;
        m1_n <= 1'b1;
        repeat (3) @(posedge clk28);
        @(negedge clk28);
        check_bit("d_out_active idle", 1'b0, d_out_active);
        check_bit("plus3_drd idle", 1'b1, plus3_drd);
        check_bit("plus3_dwr idle", 1'b1, plus3_dwr);

        // tr-dos tracking follows the m1 fetch address.
        if (!is_io && is_m1) begin
            if (addr[15:8] == `TRDOS_ENTRY_HI && basic48_paged)
                m_trdos = 1'b1;
            else if (addr[15:14] != 2'b00)
                m_trdos = 1'b0;
        end
    endtask

    // ~~~~ main ~~~~~~~~~~~~~~~~~
    initial begin
        string names [N_TESTS];
        int errs_before;
        int kind;
        addr_t addr;
        logic m1v;
        names = '{"fe_write", "paging_7ffd", "fe_kempston_read",
                  "port_ff_trdos", "plus3_ports", "pager_map"};
        void'($urandom(32'ha72e55b5));
        errors = 0;
        checks = 0;
        cycles = 0;
        rst_n = 1'b0;
        a = '0;
        d_in = '0;
        {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
        machine = MACHINE_S48;
        {en_kempston, en_sinclair, magic_map, basic48_paged, port_ff_active} = '0;
        port_ff_data = '0;
        kd = `KD_IDLE;
        kempston_data = '0;
        tape_in = 1'b0;
        m_border = '0;
        {m_beeper, m_tape, m_video, m_rom128, m_lock, m_trdos} = '0;
        m_mtr = 1'b1;
        m_page128 = '0;
        m_ext = '0;
        m_dffd = '0;
        m_1ffd = '0;
        repeat (8) @(posedge clk28);
        rst_n <= 1'b1;

        for (int t = 0; t < N_TESTS; t++) begin
            test_name = names[t];
            errs_before = errors;
            @(posedge clk28);
            machine <= (t == 4) ? MACHINE_S3 : machine_t'(2'($urandom));
            magic_map <= ($urandom % 4 == 0);
            en_kempston <= 1'($urandom);
            en_sinclair <= 1'($urandom);
            basic48_paged <= (t == 3) ? 1'b1 : 1'($urandom);
            port_ff_active <= (t == 3) ? 1'b1 : 1'($urandom);
            repeat (3) @(posedge clk28);
            for (int n = 0; n < N_CYCLES; n++) begin
                kind = $urandom % 3;
                if (kind == 2) begin
                    m1v = 1'($urandom);
                    addr = addr_t'($urandom);
                    if ($urandom % 3 == 0)
                        addr[15:8] = `TRDOS_ENTRY_HI;
                    bus_cycle(1'b0, !m1v && 1'($urandom), m1v, addr, byte_t'($urandom));
                end else begin
                    bus_cycle(1'b1, kind == 0, 1'b0, pick_addr(), byte_t'($urandom));
                end
            end
            if (errors == errs_before)
                $display("test %s: ok", test_name);
            else
                $display("test %s: %0d errors", test_name, errors - errs_before);
        end

        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
